// File: src/spi_flash_macros.svh
`ifndef SPI_FLASH_MACROS_SVH
`define SPI_FLASH_MACROS_SVH

// Flash READ opcode
`define SPI_READ_OP 8'h03

// sys_clk cycles per SCK half period
`define SPI_HALF_CYCLES 5

// Receive buffer entries
`define RX_DEPTH 16

// Register word offsets on wb_adr[3:2]
`define REG_ADDR 2'd0
`define REG_LEN  2'd1
`define REG_CTRL 2'd2
`define REG_DATA 2'd3

`endif

// File: src/spi_flash_pkg.sv
`default_nettype none

package spi_flash_pkg;

    // Host command as latched by the register block
    typedef struct packed {
        logic [23:0] addr;
        logic [3:0]  len_m1;      // Byte count minus one
    } flash_cmd_t;

    typedef struct packed {
        logic busy;
        logic done;
    } seq_status_t;

    // Sequencer to shift engine
    typedef struct packed {
        logic       go;           // One-cycle start
        logic [7:0] tx_byte;
    } shift_req_t;

    typedef struct packed {
        logic       byte_done;    // One-cycle pulse
        logic [7:0] rx_byte;
    } shift_rsp_t;

endpackage

`default_nettype wire

// File: src/flash_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_flash_macros.svh"

module flash_ctrl_regs (
    input  wire                             sys_clk,
    input  wire                             sys_rst_n,
    input  wire                             wb_cyc,
    input  wire                             wb_stb,
    input  wire                             wb_we,
    input  wire [3:2]                       wb_adr,
    input  wire [31:0]                      wb_dat_w,
    input  wire spi_flash_pkg::seq_status_t status,
    input  wire [7:0]                       pop_data,
    input  wire [4:0]                       count,
    output logic                            wb_ack,
    output logic [31:0]                     wb_dat_r,
    output logic                            start,
    output spi_flash_pkg::flash_cmd_t       cmd,
    output logic                            pop
);

    logic access;
    logic wr_ok;

    // New access only while ack is low, so each one takes two cycles
    assign access = wb_cyc && wb_stb && !wb_ack;

    // Command registers are locked during a transaction
    assign wr_ok = access && wb_we && !status.busy;

    // Head entry leaves the buffer as the read is acknowledged
    assign pop = access && !wb_we && (wb_adr == `REG_DATA);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            cmd    <= '0;
        end else begin
            wb_ack <= access;
            start  <= wr_ok && (wb_adr == `REG_CTRL) && wb_dat_w[0];
            if (wr_ok && (wb_adr == `REG_ADDR))
                cmd.addr <= wb_dat_w[23:0];
            if (wr_ok && (wb_adr == `REG_LEN))
                cmd.len_m1 <= wb_dat_w[3:0];
        end
    end

    // Read data is captured with the ack
    always_ff @(posedge sys_clk) begin
        if (access && !wb_we) begin
            case (wb_adr)
                `REG_ADDR: begin
                    wb_dat_r <= {8'h00, cmd.addr};
                end
                `REG_LEN: begin
                    wb_dat_r <= {28'h0, cmd.len_m1};
                end
                `REG_CTRL: begin
                    wb_dat_r <= {19'h0, count, 6'h0, status.done, status.busy};
                end
                default: begin
                    // Empty buffer reads as zero
                    wb_dat_r <= (count == 5'd0) ? 32'h0 : {24'h0, pop_data};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/flash_read_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_flash_macros.svh"

module flash_read_seq (
    input  wire                             sys_clk,
    input  wire                             sys_rst_n,
    input  wire                             start,
    input  wire spi_flash_pkg::flash_cmd_t  cmd,
    input  wire spi_flash_pkg::shift_rsp_t  shift_rsp,
    output spi_flash_pkg::shift_req_t       shift_req,
    output logic                            spi_cs_n,
    output spi_flash_pkg::seq_status_t      status,
    output logic                            push,
    output logic [7:0]                      push_data
);

    import spi_flash_pkg::*;

    typedef enum logic [1:0] {IDLE, CMD, DATA, END} state_t;

    state_t     state;
    flash_cmd_t cmd_q;
    logic [1:0] byte_idx;     // Header byte in flight
    logic [3:0] data_cnt;     // Data bytes done so far
    logic       go;
    logic [7:0] tx_byte;
    logic       accept;

    // END holds done until the next start
    assign accept = start && ((state == IDLE) || (state == END));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= IDLE;
            spi_cs_n <= 1'b1;
            go       <= 1'b0;
            byte_idx <= 2'd0;
            data_cnt <= 4'd0;
        end else begin
            go <= 1'b0;
            case (state)
                CMD: begin
                    if (shift_rsp.byte_done) begin
                        go       <= 1'b1;
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3)
                            state <= DATA;
                    end
                end
                DATA: begin
                    if (shift_rsp.byte_done) begin
                        if (data_cnt == cmd_q.len_m1) begin
                            state    <= END;
                            spi_cs_n <= 1'b1;
                        end else begin
                            go       <= 1'b1;
                            data_cnt <= data_cnt + 4'd1;
                        end
                    end
                end
                default: begin
                    if (accept) begin
                        state    <= CMD;
                        spi_cs_n <= 1'b0;
                        go       <= 1'b1;   // Opcode goes out with cs_n low
                        byte_idx <= 2'd0;
                        data_cnt <= 4'd0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept)
            cmd_q <= cmd;
    end

    // Opcode and address MSB first, then zeros while reading
    always_comb begin
        if (state == CMD) begin
            case (byte_idx)
                2'd0:    tx_byte = `SPI_READ_OP;
                2'd1:    tx_byte = cmd_q.addr[23:16];
                2'd2:    tx_byte = cmd_q.addr[15:8];
                default: tx_byte = cmd_q.addr[7:0];
            endcase
        end else begin
            tx_byte = 8'h00;
        end
    end

    assign shift_req = '{go: go, tx_byte: tx_byte};

    assign status = '{busy: (state == CMD) || (state == DATA), done: (state == END)};

    // Only data-phase bytes reach the buffer
    assign push      = (state == DATA) && shift_rsp.byte_done;
    assign push_data = shift_rsp.rx_byte;

endmodule

`default_nettype wire

// File: src/spi_shift_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_flash_macros.svh"

module spi_shift_engine (
    input  wire                             sys_clk,
    input  wire                             sys_rst_n,
    input  wire                             spi_miso,
    input  wire spi_flash_pkg::shift_req_t  req,
    output spi_flash_pkg::shift_rsp_t       rsp,
    output logic                            spi_sck,
    output logic                            spi_mosi
);

    localparam int HALF = `SPI_HALF_CYCLES;
    localparam int HW   = $clog2(HALF + 1);

    logic          active;
    logic [HW-1:0] half_cnt;
    logic [3:0]    edge_cnt;  // 16 SCK edges per byte
    logic [7:0]    tx_sr;
    logic [7:0]    rx_sr;
    logic          done_q;
    logic          half_end;

    assign half_end = active && (half_cnt == HW'(HALF - 1));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            active   <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= 4'd0;
            spi_sck  <= 1'b0;
            tx_sr    <= 8'h00;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!active) begin
                if (req.go) begin
                    active <= 1'b1;
                    tx_sr  <= req.tx_byte;      // MSB on MOSI while SCK is low
                end
            end else if (half_end) begin
                half_cnt <= '0;
                edge_cnt <= edge_cnt + 4'd1;
                spi_sck  <= ~spi_sck;
                if (spi_sck)
                    tx_sr <= {tx_sr[6:0], 1'b0};    // Next bit on the fall
                if (edge_cnt == 4'd15) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + HW'(1);
            end
        end
    end

    // MISO sampled as SCK rises
    always_ff @(posedge sys_clk) begin
        if (half_end && !spi_sck)
            rx_sr <= {rx_sr[6:0], spi_miso};
    end

    assign spi_mosi = tx_sr[7];
    assign rsp      = '{byte_done: done_q, rx_byte: rx_sr};

endmodule

`default_nettype wire

// File: src/rx_byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_flash_macros.svh"

module rx_byte_fifo (
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         clear,
    input  wire         push,
    input  wire [7:0]   push_data,
    input  wire         pop,
    output logic [7:0]  pop_data,
    output logic [4:0]  count
);

    localparam int DEPTH = `RX_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_pop;

    assign do_pop = pop && (count != 5'd0);     // Empty pop ignored

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 5'd0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 5'd0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + AW'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + AW'(1);
            case ({push, do_pop})
                2'b10:   count <= count + 5'd1;
                2'b01:   count <= count - 5'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/flash_reader_top.sv
`timescale 1ns/1ns
`default_nettype none

module flash_reader_top (
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire [3:2]   wb_adr,
    input  wire [31:0]  wb_dat_w,
    input  wire         spi_miso,
    output wire         wb_ack,
    output wire [31:0]  wb_dat_r,
    output wire         spi_sck,
    output wire         spi_mosi,
    output wire         spi_cs_n
);

    import spi_flash_pkg::*;

    wire              start;      // Also clears the buffer
    wire flash_cmd_t  cmd;
    wire seq_status_t status;
    wire shift_req_t  shift_req;
    wire shift_rsp_t  shift_rsp;
    wire              push;
    wire [7:0]        push_data;
    wire              pop;
    wire [7:0]        pop_data;
    wire [4:0]        count;

    flash_ctrl_regs i_ctrl_regs (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .status    (status),
        .pop_data  (pop_data),
        .count     (count),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .start     (start),
        .cmd       (cmd),
        .pop       (pop)
    );

    flash_read_seq i_read_seq (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .cmd       (cmd),
        .shift_rsp (shift_rsp),
        .shift_req (shift_req),
        .spi_cs_n  (spi_cs_n),
        .status    (status),
        .push      (push),
        .push_data (push_data)
    );

    spi_shift_engine i_shift_engine (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .spi_miso  (spi_miso),
        .req       (shift_req),
        .rsp       (shift_rsp),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi)
    );

    rx_byte_fifo i_rx_fifo (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .clear     (start),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .count     (count)
    );

endmodule

`default_nettype wire

// File: bench/spi_flash_model.sv
`timescale 1ns/1ns
`default_nettype none

module spi_flash_model (
    input  wire         spi_sck,
    input  wire         spi_mosi,
    input  wire         spi_cs_n,
    output logic        spi_miso,
    output logic [7:0]  last_opcode,
    output logic [23:0] last_addr
);

    logic [31:0] hdr_sr;
    logic [8:0]  bit_cnt;     // SCK rises since cs_n fell
    logic [7:0]  out_byte;

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    initial begin
        spi_miso    = 1'b0;
        hdr_sr      = 32'h0;
        bit_cnt     = 9'd0;
        out_byte    = 8'h00;
        last_opcode = 8'h00;
        last_addr   = 24'h0;
    end

    // cs_n falls while SCK is low, so a low SCK marks a new command
    always @(posedge spi_sck or negedge spi_cs_n) begin
        if (!spi_sck) begin
            bit_cnt <= 9'd0;
        end else if (!spi_cs_n) begin
            bit_cnt <= bit_cnt + 9'd1;
            hdr_sr  <= {hdr_sr[30:0], spi_mosi};
            if (bit_cnt == 9'd31)
                {last_opcode, last_addr} <= {hdr_sr[30:0], spi_mosi};
        end
    end

    // Data bits change on SCK falls, first one right after the header
    always @(negedge spi_sck) begin
        if (!spi_cs_n && bit_cnt >= 9'd32) begin
            out_byte = flash_byte(last_addr + 24'(bit_cnt[8:3] - 6'd4));
            spi_miso <= out_byte[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_flash_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_flash_macros.svh"

module tb_flash_reader;

    localparam int MAX_CYCLES = 20000;  // About ten 16-byte reads plus register traffic

    logic        sys_clk;
    logic        sys_rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:2]  wb_adr;
    logic [31:0] wb_dat_w;
    wire         wb_ack;
    wire  [31:0] wb_dat_r;
    wire         spi_sck;
    wire         spi_mosi;
    wire         spi_cs_n;
    wire         spi_miso;
    wire  [7:0]  model_opcode;
    wire  [23:0] model_addr;

    logic [31:0] lfsr;
    int          cycle_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          test_num;
    int          test_fail_base;
    string       test_name;
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    string       cmp_name;
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;

    flash_reader_top i_flash_reader_top (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .spi_miso  (spi_miso),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n)
    );

    spi_flash_model i_flash_model (
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n),
        .spi_miso    (spi_miso),
        .last_opcode (model_opcode),
        .last_addr   (model_addr)
    );

    always #50 sys_clk = ~sys_clk;

    // Expected flash content at one address
    function automatic logic [7:0] expected_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(posedge sys_clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge sys_clk);
            #1;
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // Compare process
    always @(negedge sys_clk) begin
        while (got_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_got  = got_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            assert (cmp_got === cmp_exp) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
                $display("ERROR %s: got 0x%h, expected 0x%h", cmp_name, cmp_got, cmp_exp);
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_num++;
        test_name      = name;
        test_fail_base = fail_cnt;
    endtask

    task automatic end_test();
        @(negedge sys_clk);     // Let queued compares drain
        #1;
        $display("Test %0d %s: %s", test_num, test_name,
                 (fail_cnt == test_fail_base) ? "ok" : "mismatch");
    endtask

    task automatic start_read(input logic [23:0] addr, input int len);
        wb_write(`REG_ADDR, {8'h00, addr});
        wb_write(`REG_LEN, 32'(len - 1));
        wb_write(`REG_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        rd = '0;
        while (!rd[1])
            wb_read(`REG_CTRL, rd);
    endtask

    task automatic check_read(input logic [23:0] addr, input int len);
        logic [31:0] rd;
        expect_value("model opcode", model_opcode, 32'h03);    // Flash READ
        expect_value("model address", model_addr, addr);
        wb_read(`REG_CTRL, rd);
        expect_value("wb_dat_r CTRL", rd, (32'(len) << 8) | 32'h2);  // Done, count
        for (int i = 0; i < len; i++) begin
            wb_read(`REG_DATA, rd);
            expect_value("wb_dat_r DATA", rd, expected_byte(addr + 24'(i)));
        end
        wb_read(`REG_DATA, rd);
        expect_value("wb_dat_r DATA empty", rd, 32'h0);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rnd_addr;
        logic [31:0] rnd_len;
        sys_clk   = 1'b0;
        sys_rst_n = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 2'd0;
        wb_dat_w  = 32'h0;
        lfsr      = 32'h9fddd792;
        cycle_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_num  = 0;
        repeat (2) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;

        start_test("reset state");
        expect_value("spi_cs_n", spi_cs_n, 1);
        expect_value("spi_sck", spi_sck, 0);
        expect_value("spi_mosi", spi_mosi, 0);
        wb_read(`REG_CTRL, rd);
        expect_value("wb_dat_r CTRL", rd, 32'h0);
        wb_read(`REG_DATA, rd);
        expect_value("wb_dat_r DATA", rd, 32'h0);
        end_test();

        start_test("one byte at 0");
        start_read(24'h000000, 1);
        wait_done();
        check_read(24'h000000, 1);
        end_test();

        start_test("16 bytes with wrap");
        start_read(24'hfffff8, 16);
        wait_done();
        check_read(24'hfffff8, 16);
        end_test();

        start_test("random reads");
        repeat (6) begin
            random_bits(24, rnd_addr);
            random_bits(4, rnd_len);
            start_read(rnd_addr[23:0], rnd_len + 1);
            wait_done();
            check_read(rnd_addr[23:0], rnd_len + 1);
        end
        end_test();

        start_test("busy write lock");
        start_read(24'h123456, 16);
        wb_read(`REG_CTRL, rd);
        expect_value("CTRL busy", rd[0], 1);
        wb_write(`REG_ADDR, 32'h00abcdef);
        wb_write(`REG_LEN, 32'h2);
        wb_write(`REG_CTRL, 32'h1);
        wb_read(`REG_ADDR, rd);
        expect_value("wb_dat_r ADDR", rd, 32'h00123456);
        wb_read(`REG_LEN, rd);
        expect_value("wb_dat_r LEN", rd, 32'hf);
        wait_done();
        check_read(24'h123456, 16);
        end_test();

        start_test("start clears buffer");
        start_read(24'h00a5a0, 5);
        wait_done();
        start_read(24'h3c0001, 3);
        wait_done();
        check_read(24'h3c0001, 3);
        end_test();

        $display("Summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/spi_flash_pkg.sv
src/flash_ctrl_regs.sv
src/flash_read_seq.sv
src/spi_shift_engine.sv
src/rx_byte_fifo.sv
src/flash_reader_top.sv
bench/spi_flash_model.sv
bench/tb_flash_reader.sv
